//--- design/dma_aligner.sv
module dma_aligner #(
  parameter bit UP = 1'b1                    // 1 aligns upward to lane 0, 0 shifts to dst offset
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [dma_pkg::OFS_W-1:0]   src_addr,
  input  logic [dma_pkg::OFS_W-1:0]   dst_addr,
  input  logic [dma_pkg::DATA_W-1:0]  datai,
  input  logic                        datai_en,
  input  logic                        datai_last,
  output logic [dma_pkg::DATA_W-1:0]  datao,
  output logic                        datao_en
);
  import dma_pkg::*;

  logic [OFS_W-1:0]    rot_next;             // Rotation for the coming copy
  logic [OFS_W-1:0]    align_rot;            // Bytes to rotate left
  logic [DATA_W-1:0]   align_mask;           // Set lanes come from the current word
  logic                first_is_merged;      // First word waits for its partner
  logic                last;                 // Final input captured, flush from here on
  logic [2*DATA_W-1:0] data_dbl;
  logic [DATA_W-1:0]   data_rot;
  logic [DATA_W-1:0]   data_rot_1t;          // Previous rotated word

  // Upward undoes the source offset, downward applies the destination offset
  assign rot_next = UP ? (3'd0 - src_addr) : dst_addr;

  // --------------------
  // Byte rotation
  // --------------------
  // Doubled word shifted left, upper half is the rotated word
  assign data_dbl = {datai, datai} << {align_rot, 3'b000};
  assign data_rot = data_dbl[2*DATA_W-1:DATA_W];

  // --------------------
  // Setup and last state
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      align_rot       <= '0;
      align_mask      <= '0;
      first_is_merged <= 1'b0;
      last            <= 1'b0;
    end
    else if (start)
    begin
      align_rot  <= rot_next;
      align_mask <= {DATA_W{1'b1}} << {rot_next, 3'b000};  // Lanes at rot and up
      // Nonzero source offset needs two words for the first output
      first_is_merged <= UP && (src_addr != '0);
      last            <= 1'b0;
    end
    else if (datai_en && !last)
    begin
      first_is_merged <= 1'b0;
      if (datai_last)
        last <= 1'b1;                          // Held until the next start
    end
  end

  // Merge buffer, frozen once the last word is in
  always_ff @(posedge clk)
  begin
    if (datai_en && !last)
      data_rot_1t <= data_rot;
  end

  // --------------------
  // Merge
  // --------------------
  // Low lanes from the previous word, high lanes from the current one
  assign datao = (data_rot_1t & ~align_mask) | (data_rot & align_mask);

  // Flush steps pass on last, the first step is swallowed when merging
  assign datao_en = datai_en && (last || !first_is_merged);

endmodule

//--- design/dma_copy_top.sv
module dma_copy_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cfg_cyc,
  input  logic                         cfg_stb,
  input  logic                         cfg_we,
  input  logic [1:0]                   cfg_adr,
  input  logic [dma_pkg::CFG_W-1:0]    cfg_dat_i,
  output logic [dma_pkg::CFG_W-1:0]    cfg_dat_o,
  output logic                         cfg_ack,
  output logic                         src_cyc,
  output logic                         src_stb,
  output logic [dma_pkg::WADR_W-1:0]   src_adr,
  input  logic [dma_pkg::DATA_W-1:0]   src_dat_i,
  input  logic                         src_ack,
  output logic                         dst_cyc,
  output logic                         dst_stb,
  output logic                         dst_we,
  output logic [dma_pkg::WADR_W-1:0]   dst_adr,
  output logic [dma_pkg::BYTES_W-1:0]  dst_sel,
  output logic [dma_pkg::DATA_W-1:0]   dst_dat_o,
  input  logic                         dst_ack,
  output logic                         done
);
  import dma_pkg::*;

  logic              start;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic [LEN_W-1:0]  len;
  logic              busy;
  logic              store_ready;
  logic              store_done;
  logic [DATA_W-1:0] up_din;                 // Source word into the chain
  logic              up_en;
  logic              up_last;
  logic [DATA_W-1:0] up_dout;                // Word aligned stream
  logic              up_dout_en;
  logic              dn_last;
  logic [DATA_W-1:0] dn_dout;                // Shifted to the dst offset
  logic              dn_en;

  // --------------------
  // Control and source side
  // --------------------
  dma_regs regs_i (
    .clk, .rst_n, .cfg_cyc, .cfg_stb, .cfg_we, .cfg_adr, .cfg_dat_i, .cfg_dat_o, .cfg_ack,
    .busy, .store_done, .start, .src_addr, .dst_addr, .len, .done
  );

  dma_fetch fetch_i (
    .clk, .rst_n, .start, .src_addr, .len, .src_cyc, .src_stb, .src_adr, .src_dat_i,
    .src_ack, .store_ready, .store_done, .up_din, .up_en, .up_last, .dn_last, .busy
  );

  // --------------------
  // Aligner chain
  // --------------------
  dma_aligner #(.UP(1'b1)) up_aligner_i (
    .clk, .rst_n, .start,
    .src_addr(src_addr[OFS_W-1:0]), .dst_addr(dst_addr[OFS_W-1:0]),
    .datai(up_din), .datai_en(up_en), .datai_last(up_last),
    .datao(up_dout), .datao_en(up_dout_en)
  );

  dma_aligner #(.UP(1'b0)) dn_aligner_i (
    .clk, .rst_n, .start,
    .src_addr(src_addr[OFS_W-1:0]), .dst_addr(dst_addr[OFS_W-1:0]),
    .datai(up_dout), .datai_en(up_dout_en), .datai_last(dn_last),
    .datao(dn_dout), .datao_en(dn_en)
  );

  // Destination side
  dma_store store_i (
    .clk, .rst_n, .start, .dst_addr, .len, .dn_dout, .dn_en, .store_ready, .store_done,
    .dst_cyc, .dst_stb, .dst_we, .dst_adr, .dst_sel, .dst_dat_o, .dst_ack
  );

endmodule

//--- design/dma_fetch.sv
module dma_fetch (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [dma_pkg::ADDR_W-1:0]  src_addr,
  input  logic [dma_pkg::LEN_W-1:0]   len,
  output logic                        src_cyc,
  output logic                        src_stb,
  output logic [dma_pkg::WADR_W-1:0]  src_adr,
  input  logic [dma_pkg::DATA_W-1:0]  src_dat_i,
  input  logic                        src_ack,
  input  logic                        store_ready,
  input  logic                        store_done,
  output logic [dma_pkg::DATA_W-1:0]  up_din,
  output logic                        up_en,
  output logic                        up_last,
  output logic                        dn_last,
  output logic                        busy
);
  import dma_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_STEP, S_READ, S_FLUSH} state_t;

  state_t            state;
  logic [LEN_W:0]    src_span;               // Offset + len + 7
  logic [LEN_W:0]    mid_span;               // len + 7
  logic [WCNT_W-1:0] n_src;                  // Source words touched
  logic [WCNT_W-1:0] n_mid;                  // Aligned words in the stream
  logic [WCNT_W-1:0] rd_cnt;                 // Source words acknowledged
  logic [WCNT_W-1:0] out_cnt;                // Words out of the upward aligner
  logic              merge_first;            // Upward aligner swallows step one
  logic              first_step;
  logic              delivered;

  assign src_span = {1'b0, len} + src_addr[OFS_W-1:0] + (LEN_W+1)'(7);
  assign mid_span = {1'b0, len} + (LEN_W+1)'(7);

  // --------------------
  // Step generation
  // --------------------
  assign up_din    = src_dat_i;               // Read data goes straight in
  assign up_en     = ((state == S_READ) && src_ack) || ((state == S_FLUSH) && store_ready);
  assign up_last   = (state == S_READ) && src_ack && (rd_cnt == n_src - 1'b1);
  assign delivered = up_en && !(first_step && merge_first);
  assign dn_last   = delivered && (out_cnt == n_mid - 1'b1);  // N_mid-th aligned word
  assign busy      = (state != S_IDLE);

  // --------------------
  // Sequencer
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= S_IDLE;
      src_cyc     <= 1'b0;
      src_stb     <= 1'b0;
      src_adr     <= '0;
      n_src       <= '0;
      n_mid       <= '0;
      rd_cnt      <= '0;
      out_cnt     <= '0;
      merge_first <= 1'b0;
      first_step  <= 1'b0;
    end
    else
    begin
      if (up_en)
        first_step <= 1'b0;
      if (delivered)
        out_cnt <= out_cnt + 1'b1;
      case (state)
        S_IDLE:
        begin
          if (start)
          begin
            n_src       <= src_span[LEN_W:OFS_W];
            n_mid       <= mid_span[LEN_W:OFS_W];
            merge_first <= (src_addr[OFS_W-1:0] != '0);
            src_adr     <= src_addr[ADDR_W-1:OFS_W];
            rd_cnt      <= '0;
            out_cnt     <= '0;
            first_step  <= 1'b1;
            state       <= S_STEP;
          end
        end
        S_STEP:                              // Wait for room in the store
        begin
          if (store_done)
            state <= S_IDLE;
          else if (store_ready)
          begin
            if (rd_cnt != n_src)
            begin
              src_cyc <= 1'b1;
              src_stb <= 1'b1;
              state   <= S_READ;
            end
            else
              state <= S_FLUSH;
          end
        end
        S_READ:                              // Step taken on the ack
        begin
          if (src_ack)
          begin
            src_cyc <= 1'b0;
            src_stb <= 1'b0;
            src_adr <= src_adr + 1'b1;
            rd_cnt  <= rd_cnt + 1'b1;
            state   <= S_STEP;
          end
        end
        default:                             // Flush until the store is done
        begin
          if (store_done)
            state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- design/dma_pkg.sv
package dma_pkg;

  // --------------------
  // Data path
  // --------------------
  localparam int DATA_W  = 64;               // Bits per data word
  localparam int BYTES_W = 8;                // Byte lanes per word, lane 0 is the LSB
  localparam int OFS_W   = 3;                // Byte offset inside a word

  // --------------------
  // Addresses and lengths
  // --------------------
  localparam int ADDR_W = 16;                // Byte address
  localparam int WADR_W = ADDR_W - OFS_W;    // Word address, byte address divided by 8
  localparam int LEN_W  = 12;                // Byte length, 1 to 4095
  localparam int WCNT_W = LEN_W - 2;         // Word counts up to 513

  // Byte A sits in word A / 8 and lane A % 8, so word counts
  // come from (offset + len + 7) / 8

  // --------------------
  // Configuration bus
  // --------------------
  localparam int CFG_W = 32;

  localparam logic [1:0] REG_SRC  = 2'd0;    // Source byte address
  localparam logic [1:0] REG_DST  = 2'd1;    // Destination byte address
  localparam logic [1:0] REG_LEN  = 2'd2;    // Length in bytes
  localparam logic [1:0] REG_CTRL = 2'd3;    // Go on write, busy and done on read

endpackage

//--- design/dma_regs.sv
module dma_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cfg_cyc,
  input  logic                        cfg_stb,
  input  logic                        cfg_we,
  input  logic [1:0]                  cfg_adr,
  input  logic [dma_pkg::CFG_W-1:0]   cfg_dat_i,
  output logic [dma_pkg::CFG_W-1:0]   cfg_dat_o,
  output logic                        cfg_ack,
  input  logic                        busy,
  input  logic                        store_done,
  output logic                        start,
  output logic [dma_pkg::ADDR_W-1:0]  src_addr,
  output logic [dma_pkg::ADDR_W-1:0]  dst_addr,
  output logic [dma_pkg::LEN_W-1:0]   len,
  output logic                        done
);
  import dma_pkg::*;

  logic wr;                                  // Write completing this cycle
  logic go;                                  // Accepted go bit

  assign wr = cfg_ack && cfg_cyc && cfg_stb && cfg_we;
  assign go = wr && (cfg_adr == REG_CTRL) && cfg_dat_i[0] && !busy && !start;

  // --------------------
  // Bus handshake
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cfg_ack <= 1'b0;
    else
      cfg_ack <= cfg_cyc && cfg_stb && !cfg_ack;  // Single cycle, one after stb
  end

  // --------------------
  // Setup and status
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      src_addr <= '0;
      dst_addr <= '0;
      len      <= '0;
      start    <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      start <= go;                           // One cycle after the acked write
      if (wr && !busy)                       // Frozen during a copy
      begin
        case (cfg_adr)
          REG_SRC: src_addr <= cfg_dat_i[ADDR_W-1:0];
          REG_DST: dst_addr <= cfg_dat_i[ADDR_W-1:0];
          REG_LEN: len      <= cfg_dat_i[LEN_W-1:0];
          default: ;                         // Control handled by go
        endcase
      end
      if (store_done)
        done <= 1'b1;
      else if (go)
        done <= 1'b0;
    end
  end

  // Read mux, valid while ack is high
  always_comb
  begin
    case (cfg_adr)
      REG_SRC: cfg_dat_o = CFG_W'(src_addr);
      REG_DST: cfg_dat_o = CFG_W'(dst_addr);
      REG_LEN: cfg_dat_o = CFG_W'(len);
      default: cfg_dat_o = CFG_W'({done, busy});
    endcase
  end

endmodule

//--- design/dma_store.sv
module dma_store (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [dma_pkg::ADDR_W-1:0]   dst_addr,
  input  logic [dma_pkg::LEN_W-1:0]    len,
  input  logic [dma_pkg::DATA_W-1:0]   dn_dout,
  input  logic                         dn_en,
  output logic                         store_ready,
  output logic                         store_done,
  output logic                         dst_cyc,
  output logic                         dst_stb,
  output logic                         dst_we,
  output logic [dma_pkg::WADR_W-1:0]   dst_adr,
  output logic [dma_pkg::BYTES_W-1:0]  dst_sel,
  output logic [dma_pkg::DATA_W-1:0]   dst_dat_o,
  input  logic                         dst_ack
);
  import dma_pkg::*;

  logic [LEN_W:0]     dst_span;              // Offset + len + 7
  logic [OFS_W-1:0]   end_lane;              // Lane of the final byte
  logic [WCNT_W-1:0]  n_dst;                 // Destination words touched
  logic [WCNT_W-1:0]  wr_cnt;                // Words captured so far
  logic [BYTES_W-1:0] head_sel;              // Lanes from the dst offset up
  logic [BYTES_W-1:0] tail_sel;              // Lanes up to the final byte
  logic [BYTES_W-1:0] sel_next;
  logic               active;
  logic               take;                  // Word captured this cycle

  assign dst_span = {1'b0, len} + dst_addr[OFS_W-1:0] + (LEN_W+1)'(7);
  assign end_lane = dst_addr[OFS_W-1:0] + len[OFS_W-1:0] - 1'b1;  // Wraps in 3 bits

  assign dst_we      = 1'b1;                 // Write-only port
  assign store_ready = active && !dst_cyc && (wr_cnt != n_dst);
  assign take        = dn_en && store_ready;

  // Both limits apply at once when the copy fits in one word
  always_comb
  begin
    sel_next = {BYTES_W{1'b1}};
    if (wr_cnt == '0)
      sel_next = sel_next & head_sel;
    if (wr_cnt == n_dst - 1'b1)
      sel_next = sel_next & tail_sel;
  end

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active     <= 1'b0;
      dst_cyc    <= 1'b0;
      dst_stb    <= 1'b0;
      wr_cnt     <= '0;
      n_dst      <= '0;
      head_sel   <= '0;
      tail_sel   <= '0;
      store_done <= 1'b0;
    end
    else
    begin
      store_done <= 1'b0;
      if (start)
      begin
        active   <= 1'b1;
        wr_cnt   <= '0;
        n_dst    <= dst_span[LEN_W:OFS_W];
        head_sel <= {BYTES_W{1'b1}} << dst_addr[OFS_W-1:0];
        tail_sel <= {BYTES_W{1'b1}} >> (3'd7 - end_lane);
      end
      else if (take)
      begin
        dst_cyc <= 1'b1;                     // On the bus next cycle
        dst_stb <= 1'b1;
        wr_cnt  <= wr_cnt + 1'b1;
      end
      else if (dst_cyc && dst_ack)
      begin
        dst_cyc <= 1'b0;
        dst_stb <= 1'b0;
        if (wr_cnt == n_dst)                 // Final word written
        begin
          active     <= 1'b0;
          store_done <= 1'b1;
        end
      end
    end
  end

  // Holding register and address pointer
  always_ff @(posedge clk)
  begin
    if (start)
      dst_adr <= dst_addr[ADDR_W-1:OFS_W];
    else if (dst_cyc && dst_ack)
      dst_adr <= dst_adr + 1'b1;
    if (take)
    begin
      dst_dat_o <= dn_dout;
      dst_sel   <= sel_next;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module dma_copy_tb \
  -o dma_copy_sim \
  && ./obj_dir/dma_copy_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^ALL TESTS PASSED$" sim.log \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

//--- sources.f
design/dma_pkg.sv
design/dma_aligner.sv
design/dma_regs.sv
design/dma_fetch.sv
design/dma_store.sv
design/dma_copy_top.sv
tests/wb_mem_model.sv
tests/dma_copy_tb.sv

//--- tests/dma_copy_tb.sv
module dma_copy_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import dma_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int ACK_TIMEOUT = 20;           // Cycles per configuration access
  localparam int POLL_LIMIT  = 1000;         // Status reads per copy

  logic               clk;
  logic               rst_n;
  logic               cfg_cyc;
  logic               cfg_stb;
  logic               cfg_we;
  logic [1:0]         cfg_adr;
  logic [CFG_W-1:0]   cfg_dat_i;
  logic [CFG_W-1:0]   cfg_dat_o;
  logic               cfg_ack;
  logic               src_cyc;
  logic               src_stb;
  logic [WADR_W-1:0]  src_adr;
  logic [DATA_W-1:0]  src_dat_i;
  logic               src_ack;
  logic               dst_cyc;
  logic               dst_stb;
  logic               dst_we;
  logic [WADR_W-1:0]  dst_adr;
  logic [BYTES_W-1:0] dst_sel;
  logic [DATA_W-1:0]  dst_dat_o;
  logic               dst_ack;
  logic               copy_done;

  logic [DATA_W-1:0]  src_img [0:MEM_WORDS-1];  // Source as loaded
  logic [DATA_W-1:0]  exp_img [0:MEM_WORDS-1];  // Expected destination
  integer             seed = 19;
  int                 errors = 0;
  int                 checks = 0;
  int                 timeouts = 0;
  int                 copy_no = 0;
  bit                 abort = 1'b0;          // Set on a timeout, skips the rest
  event               check_ev;

  // --------------------
  // DUT and memories
  // --------------------
  dma_copy_top dut_i (
    .clk, .rst_n, .cfg_cyc, .cfg_stb, .cfg_we, .cfg_adr, .cfg_dat_i, .cfg_dat_o, .cfg_ack,
    .src_cyc, .src_stb, .src_adr, .src_dat_i, .src_ack,
    .dst_cyc, .dst_stb, .dst_we, .dst_adr, .dst_sel, .dst_dat_o, .dst_ack,
    .done(copy_done)
  );

  wb_mem_model #(.DEPTH(MEM_WORDS), .SEED(19)) src_mem_i (
    .clk, .rst_n, .cyc(src_cyc), .stb(src_stb), .we(1'b0), .adr(src_adr),
    .sel('0), .dat_i('0), .dat_o(src_dat_i), .ack(src_ack)
  );

  wb_mem_model #(.DEPTH(MEM_WORDS), .SEED(19)) dst_mem_i (
    .clk, .rst_n, .cyc(dst_cyc), .stb(dst_stb), .we(dst_we), .adr(dst_adr),
    .sel(dst_sel), .dat_i(dst_dat_o), .dat_o(), .ack(dst_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;                  // 40 ns period
  end

  // --------------------
  // Reference and compare
  // --------------------
  // Byte A is word A / 8, lane A % 8
  function automatic void ref_copy(input int src_a, input int dst_a, input int n);
    int s;
    int d;
    for (int k = 0; k < n; k++)
    begin
      s = src_a + k;
      d = dst_a + k;
      exp_img[d / 8][(d % 8) * 8 +: 8] = src_img[s / 8][(s % 8) * 8 +: 8];
    end
  endfunction

  function automatic void check_value(input string what, input logic [DATA_W-1:0] got,
                                      input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: copy %0d %s is %h, expected %h", $time, copy_no, what,
               got, exp);
      errors++;
    end
  endfunction

  // Whole images, so bytes around the target range are covered too
  always @(check_ev)
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      check_value($sformatf("destination word %0d", i), dst_mem_i.mem[i], exp_img[i]);
  end

  // --------------------
  // Configuration bus
  // --------------------
  task automatic cfg_cycle(input logic we, input logic [1:0] adr, input logic [CFG_W-1:0] wdata,
                           output logic [CFG_W-1:0] rdata);
    int waited;
    rdata = '0;
    if (abort)
      return;
    cfg_cyc   = 1'b1;
    cfg_stb   = 1'b1;
    cfg_we    = we;
    cfg_adr   = adr;
    cfg_dat_i = wdata;
    waited    = 0;
    @(negedge clk);
    while (!cfg_ack && waited < ACK_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_ack)
    begin
      $display("Timeout: no acknowledge on the configuration bus, register %0d", adr);
      timeouts++;
      abort = 1'b1;
    end
    else
      rdata = cfg_dat_o;                     // Read mux valid with ack
    @(negedge clk);                          // Ack taken at the rising edge in between
    cfg_cyc = 1'b0;
    cfg_stb = 1'b0;
    cfg_we  = 1'b0;
    @(negedge clk);                          // Idle cycle between accesses
  endtask

  task automatic reg_write(input logic [1:0] adr, input int data);
    logic [CFG_W-1:0] unused;
    cfg_cycle(1'b1, adr, CFG_W'(data), unused);
  endtask

  task automatic reg_read(input logic [1:0] adr, output logic [CFG_W-1:0] data);
    cfg_cycle(1'b0, adr, '0, data);
  endtask

  // Fresh random images in both memories
  task automatic load_images();
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      src_img[i] = {$random(seed), $random(seed)};
      exp_img[i] = {$random(seed), $random(seed)};
      src_mem_i.mem[i] <= src_img[i];
      dst_mem_i.mem[i] <= exp_img[i];
    end
  endtask

  // --------------------
  // One copy
  // --------------------
  task automatic run_copy(input int src_a, input int dst_a, input int n, input bit probe);
    logic [CFG_W-1:0] rd;
    int               polls;
    if (abort)
      return;
    copy_no++;
    load_images();
    ref_copy(src_a, dst_a, n);
    reg_write(REG_SRC, src_a);
    reg_write(REG_DST, dst_a);
    reg_write(REG_LEN, n);
    if (probe)
    begin
      reg_read(REG_SRC, rd);
      check_value("source address register", DATA_W'(rd), DATA_W'(src_a));
      reg_read(REG_DST, rd);
      check_value("destination address register", DATA_W'(rd), DATA_W'(dst_a));
      reg_read(REG_LEN, rd);
      check_value("length register", DATA_W'(rd), DATA_W'(n));
    end
    reg_write(REG_CTRL, 1);                  // Go
    if (probe)
    begin
      reg_read(REG_CTRL, rd);
      check_value("busy bit during copy", DATA_W'(rd[0]), 1);
      reg_write(REG_SRC, src_a + 8);         // Frozen while busy
      reg_write(REG_CTRL, 1);                // Second go, ignored
    end
    rd    = '0;
    polls = 0;
    while (!abort && !rd[1] && polls < POLL_LIMIT)
    begin
      reg_read(REG_CTRL, rd);
      polls++;
    end
    if (!abort && !rd[1])
    begin
      $display("Timeout: copy %0d never reported done", copy_no);
      timeouts++;
      abort = 1'b1;
    end
    if (abort)
      return;
    check_value("busy bit after done", DATA_W'(rd[0]), 0);
    check_value("done output", DATA_W'(copy_done), 1);
    if (probe)
    begin
      reg_read(REG_SRC, rd);
      check_value("source address after copy", DATA_W'(rd), DATA_W'(src_a));
    end
    -> check_ev;
    @(negedge clk);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial
  begin
    int sa;
    int da;
    int n;
    rst_n     = 1'b0;
    cfg_cyc   = 1'b0;
    cfg_stb   = 1'b0;
    cfg_we    = 1'b0;
    cfg_adr   = '0;
    cfg_dat_i = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    run_copy(0, 1024, 64, 1'b0);             // Aligned
    run_copy(128, 1536, 24, 1'b0);
    run_copy(3, 1024, 61, 1'b0);             // Source offset only
    run_copy(5, 1200, 11, 1'b0);
    run_copy(16, 1029, 40, 1'b0);            // Destination offset only
    run_copy(2, 1035, 37, 1'b0);             // Both offsets, ragged end
    run_copy(7, 1101, 59, 1'b0);
    run_copy(3, 1100, 1, 1'b0);              // Inside one destination word
    run_copy(6, 1203, 5, 1'b0);
    run_copy(1, 1304, 7, 1'b0);
    run_copy(12, 1290, 200, 1'b1);           // Register readback and busy go

    for (int k = 0; k < 20; k++)
    begin
      n  = 1 + int'($unsigned($random(seed)) % 160);
      sa = int'($unsigned($random(seed)) % 1024);
      da = 1024 + int'($unsigned($random(seed)) % (1024 - n));
      run_copy(sa, da, n, 1'b0);
    end

    $display("Copies: %0d, checks: %0d, errors: %0d, timeouts: %0d", copy_no, checks, errors,
             timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- tests/wb_mem_model.sv
module wb_mem_model #(
  parameter int DEPTH = 256,                 // Words
  parameter int SEED  = 19                   // Start value for the ack delay sequence
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [dma_pkg::WADR_W-1:0]   adr,
  input  logic [dma_pkg::BYTES_W-1:0]  sel,
  input  logic [dma_pkg::DATA_W-1:0]   dat_i,
  output logic [dma_pkg::DATA_W-1:0]   dat_o,
  output logic                         ack
);
  timeunit 1ns;
  timeprecision 1ps;
  import dma_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [0:DEPTH-1];
  integer            seed = SEED;
  int                wait_cnt;               // Cycles spent on this access
  int                delay;                  // Ack delay, 0 to 3

  // Falling edge so the master samples a settled ack
  always @(negedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack      <= 1'b0;
      wait_cnt <= 0;
      delay    <= 0;
    end
    else if (ack)
      ack <= 1'b0;                           // Single cycle pulse
    else if (cyc && stb)
    begin
      if (wait_cnt == delay)
      begin
        ack      <= 1'b1;
        wait_cnt <= 0;
        delay    <= $unsigned($random(seed)) % 4;
        dat_o    <= mem[adr[AW-1:0]];
        for (int b = 0; b < BYTES_W; b++)
          if (we && sel[b])
            mem[adr[AW-1:0]][b*8 +: 8] <= dat_i[b*8 +: 8];  // Lane b only
      end
      else
        wait_cnt <= wait_cnt + 1;
    end
  end

endmodule
